//--- run_sim.sh
#!/bin/sh
# Build the register file testbench with Verilator, run it, then search the log

verilator --binary --timing --assert -Wno-fatal \
    --top-module prf_tb -f sources.f -o prf_sim \
    || { echo "verilator build failed"; exit 1; }

./obj_dir/prf_sim > sim.log 2>&1
cat sim.log

grep -q "all tests passed" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- sources.f
+incdir+src
src/prf_pkg.sv
src/phys_reg_file.sv
src/prf_read_port.sv
src/free_list.sv
src/prf_alloc_ctrl.sv
src/prf_top.sv
verif/prf_checker.sv
verif/prf_tb.sv

//--- src/free_list.sv
//==========================================================================
// Circular FIFO holding the free physical register indices
//==========================================================================

`include "prf_params.svh"

module free_list (
    input  logic               clk,
    input  logic               rst,
    input  logic               push,
    input  prf_pkg::preg_idx_t push_idx,
    input  logic               pop,
    output prf_pkg::preg_idx_t head_idx,
    output logic               empty
);

    // Slot storage, only slots between read and write pointer hold indices
    prf_pkg::preg_idx_t slots [`PRF_ENTRIES];

    // Pointers wrap naturally over the power-of-two depth
    logic [`PRF_IDX_W-1:0] rd_ptr;
    logic [`PRF_IDX_W-1:0] wr_ptr;

    // One extra bit so a full list is distinguishable
    logic [`PRF_IDX_W:0] count;

    logic do_push;
    logic do_pop;

    assign empty    = (count == '0);
    assign head_idx = slots[rd_ptr];

    // Pop on an empty list is dropped
    assign do_pop = pop && !empty;
    // Push into a full list is dropped
    assign do_push = push && (count != (`PRF_IDX_W+1)'(`PRF_ENTRIES));

    always_ff @(posedge clk) begin
        if (do_push) begin
            slots[wr_ptr] <= push_idx;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- src/phys_reg_file.sv
//==========================================================================
// Physical register storage with CDB writeback and allocation marking
//==========================================================================

`include "prf_params.svh"

module phys_reg_file (
    input  logic               clk,
    input  logic               rst,
    input  logic               alloc_fire,
    input  prf_pkg::preg_idx_t alloc_preg,
    input  prf_pkg::rob_id_t   alloc_rob_id,
    input  logic               cdb_valid [`CDB_PORTS],
    input  prf_pkg::preg_idx_t cdb_preg [`CDB_PORTS],
    input  prf_pkg::word_t     cdb_value [`CDB_PORTS],
    output prf_pkg::word_t     reg_value [`PRF_ENTRIES],
    output logic               reg_busy [`PRF_ENTRIES],
    output prf_pkg::rob_id_t   reg_rob_id [`PRF_ENTRIES]
);

    // Entry 0 is x0 and never holds anything
    assign reg_value[0]  = '0;
    assign reg_busy[0]   = 1'b0;
    assign reg_rob_id[0] = '0;

    // One storage slice per real physical register
    for (genvar e = 1; e < `PRF_ENTRIES; e++) begin : g_entry
        prf_pkg::word_t   value_q;
        logic             busy_q;
        prf_pkg::rob_id_t rob_id_q;
        logic             cdb_hit;
        prf_pkg::word_t   cdb_data;
        logic             alloc_hit;

        // Scan all result buses for this index
        // Later ports overwrite earlier ones so the highest port wins
        always_comb begin
            cdb_hit  = 1'b0;
            cdb_data = value_q;
            for (int p = 0; p < `CDB_PORTS; p++) begin
                if (cdb_valid[p] && (cdb_preg[p] == prf_pkg::preg_idx_t'(e))) begin
                    cdb_hit  = 1'b1;
                    cdb_data = cdb_value[p];
                end
            end
        end

        assign alloc_hit = alloc_fire && (alloc_preg == prf_pkg::preg_idx_t'(e));

        always_ff @(posedge clk) begin
            if (rst) begin
                value_q  <= '0;
                busy_q   <= 1'b0;
                rob_id_q <= '0;
            end else begin
                // Result data lands regardless of allocation
                if (cdb_hit) begin
                    value_q <= cdb_data;
                end
                // Allocation is applied last and wins the busy flag
                if (alloc_hit) begin
                    busy_q   <= 1'b1;
                    rob_id_q <= alloc_rob_id;
                end else if (cdb_hit) begin
                    busy_q <= 1'b0;
                end
            end
        end

        assign reg_value[e]  = value_q;
        assign reg_busy[e]   = busy_q;
        assign reg_rob_id[e] = rob_id_q;
    end

endmodule

//--- src/prf_alloc_ctrl.sv
//==========================================================================
// Allocation controller: free-list fill after reset, alloc and commit
//==========================================================================

`include "prf_params.svh"

module prf_alloc_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               alloc_valid,
    input  logic               commit_valid,
    input  prf_pkg::preg_idx_t commit_preg,
    input  logic               fl_empty,
    output logic               alloc_ready,
    output logic               alloc_fire,
    output logic               fl_push,
    output prf_pkg::preg_idx_t fl_push_idx,
    output logic               fl_pop
);

    // Index of the last register pushed during init
    localparam prf_pkg::preg_idx_t LAST_IDX = prf_pkg::preg_idx_t'(`PRF_ENTRIES - 1);

    prf_pkg::ctrl_state_e state;
    prf_pkg::ctrl_state_e state_next;

    // Next index to seed into the free list
    prf_pkg::preg_idx_t init_cnt;

    logic init_done;

    assign init_done = (state == prf_pkg::CTRL_INIT) && (init_cnt == LAST_IDX);

    always_comb begin
        state_next = state;
        case (state)
            prf_pkg::CTRL_INIT: begin
                if (init_done) begin
                    state_next = prf_pkg::CTRL_RUN;
                end
            end
            prf_pkg::CTRL_RUN: begin
                state_next = prf_pkg::CTRL_RUN;
            end
            default: begin
                state_next = prf_pkg::CTRL_INIT;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= prf_pkg::CTRL_INIT;
            // Index 0 is x0 so seeding starts at 1
            init_cnt <= prf_pkg::preg_idx_t'(1);
        end else begin
            state <= state_next;
            if (state == prf_pkg::CTRL_INIT) begin
                init_cnt <= init_cnt + 1'b1;
            end
        end
    end

    // Allocation only once the list is seeded and has an entry
    assign alloc_ready = (state == prf_pkg::CTRL_RUN) && !fl_empty;
    assign alloc_fire  = alloc_valid && alloc_ready;
    assign fl_pop      = alloc_fire;

    // Push mux
    // INIT seeds counter values, RUN returns committed registers
    always_comb begin
        if (state == prf_pkg::CTRL_INIT) begin
            fl_push     = 1'b1;
            fl_push_idx = init_cnt;
        end else begin
            // x0 is never returned to the list
            fl_push     = commit_valid && (commit_preg != '0);
            fl_push_idx = commit_preg;
        end
    end

endmodule

//--- src/prf_params.svh
//==========================================================================
// Sizing constants for the physical register file and rename logic
//==========================================================================

`ifndef PRF_PARAMS_SVH
`define PRF_PARAMS_SVH

// Number of physical registers including the hardwired zero entry
`define PRF_ENTRIES 64

// Width of a physical register index
`define PRF_IDX_W 6

// Width of a reorder buffer tag
`define ROB_ID_W 3

// Register data width
`define XLEN 32

// Number of common data bus result ports
`define CDB_PORTS 2

`endif

//--- src/prf_pkg.sv
//==========================================================================
// Shared types for the register file: index, tag, data, control state
//==========================================================================

`include "prf_params.svh"

package prf_pkg;

    // Physical register index
    // Value 0 stands for architectural x0
    typedef logic [`PRF_IDX_W-1:0] preg_idx_t;

    // Reorder buffer tag of the producing instruction
    typedef logic [`ROB_ID_W-1:0] rob_id_t;

    // One register value
    typedef logic [`XLEN-1:0] word_t;

    // Allocation controller states
    // INIT fills the free list after reset
    // RUN serves allocations and commits
    typedef enum logic {
        CTRL_INIT,
        CTRL_RUN
    } ctrl_state_e;

endpackage

//--- src/prf_read_port.sv
//==========================================================================
// Two-operand transparent read port with CDB forwarding
//==========================================================================

`include "prf_params.svh"

module prf_read_port (
    input  prf_pkg::preg_idx_t rs1,
    input  prf_pkg::preg_idx_t rs2,
    input  logic               cdb_valid [`CDB_PORTS],
    input  prf_pkg::preg_idx_t cdb_preg [`CDB_PORTS],
    input  prf_pkg::word_t     cdb_value [`CDB_PORTS],
    input  prf_pkg::word_t     reg_value [`PRF_ENTRIES],
    input  logic               reg_busy [`PRF_ENTRIES],
    input  prf_pkg::rob_id_t   reg_rob_id [`PRF_ENTRIES],
    output prf_pkg::word_t     rs1_value,
    output logic               rs1_busy,
    output prf_pkg::rob_id_t   rs1_rob_id,
    output prf_pkg::word_t     rs2_value,
    output logic               rs2_busy,
    output prf_pkg::rob_id_t   rs2_rob_id
);

    // Look up one operand
    // Stored entry first, then a CDB match overrides value and busy
    function automatic void read_operand(
        input  prf_pkg::preg_idx_t idx,
        output prf_pkg::word_t     value,
        output logic               busy,
        output prf_pkg::rob_id_t   rob_id
    );
        value  = reg_value[idx];
        busy   = reg_busy[idx];
        rob_id = reg_rob_id[idx];
        // Walk from the top port down so the lowest match is applied last
        for (int p = `CDB_PORTS - 1; p >= 0; p--) begin
            if (cdb_valid[p] && (cdb_preg[p] == idx)) begin
                value = cdb_value[p];
                busy  = 1'b0;
            end
        end
        // x0 reads zero even while a bus drives index 0
        if (idx == '0) begin
            value  = '0;
            busy   = 1'b0;
            rob_id = '0;
        end
    endfunction

    always_comb begin
        read_operand(rs1, rs1_value, rs1_busy, rs1_rob_id);
        read_operand(rs2, rs2_value, rs2_busy, rs2_rob_id);
    end

endmodule

//--- src/prf_top.sv
//==========================================================================
// Register file top: controller, free list, storage and three read ports
//==========================================================================

`include "prf_params.svh"

module prf_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               alloc_valid,
    input  prf_pkg::rob_id_t   alloc_rob_id,
    output logic               alloc_ready,
    output prf_pkg::preg_idx_t alloc_preg,
    input  logic               commit_valid,
    input  prf_pkg::preg_idx_t commit_preg,
    input  logic               cdb_valid [`CDB_PORTS],
    input  prf_pkg::preg_idx_t cdb_preg [`CDB_PORTS],
    input  prf_pkg::word_t     cdb_value [`CDB_PORTS],
    input  prf_pkg::preg_idx_t dispatch_rs1,
    input  prf_pkg::preg_idx_t dispatch_rs2,
    output prf_pkg::word_t     dispatch_rs1_value,
    output logic               dispatch_rs1_busy,
    output prf_pkg::rob_id_t   dispatch_rs1_rob_id,
    output prf_pkg::word_t     dispatch_rs2_value,
    output logic               dispatch_rs2_busy,
    output prf_pkg::rob_id_t   dispatch_rs2_rob_id,
    input  prf_pkg::preg_idx_t alu_rs1,
    input  prf_pkg::preg_idx_t alu_rs2,
    output prf_pkg::word_t     alu_rs1_value,
    output logic               alu_rs1_busy,
    output prf_pkg::rob_id_t   alu_rs1_rob_id,
    output prf_pkg::word_t     alu_rs2_value,
    output logic               alu_rs2_busy,
    output prf_pkg::rob_id_t   alu_rs2_rob_id,
    input  prf_pkg::preg_idx_t mul_rs1,
    input  prf_pkg::preg_idx_t mul_rs2,
    output prf_pkg::word_t     mul_rs1_value,
    output logic               mul_rs1_busy,
    output prf_pkg::rob_id_t   mul_rs1_rob_id,
    output prf_pkg::word_t     mul_rs2_value,
    output logic               mul_rs2_busy,
    output prf_pkg::rob_id_t   mul_rs2_rob_id
);

    // Controller to free list
    logic               alloc_fire;
    logic               fl_push;
    prf_pkg::preg_idx_t fl_push_idx;
    logic               fl_pop;
    logic               fl_empty;

    // Full register arrays shared by every read port
    prf_pkg::word_t   reg_value [`PRF_ENTRIES];
    logic             reg_busy [`PRF_ENTRIES];
    prf_pkg::rob_id_t reg_rob_id [`PRF_ENTRIES];

    prf_alloc_ctrl u_alloc_ctrl (
        .clk          (clk),
        .rst          (rst),
        .alloc_valid  (alloc_valid),
        .commit_valid (commit_valid),
        .commit_preg  (commit_preg),
        .fl_empty     (fl_empty),
        .alloc_ready  (alloc_ready),
        .alloc_fire   (alloc_fire),
        .fl_push      (fl_push),
        .fl_push_idx  (fl_push_idx),
        .fl_pop       (fl_pop)
    );

    // Head of the list is the next register handed out
    free_list u_free_list (
        .clk      (clk),
        .rst      (rst),
        .push     (fl_push),
        .push_idx (fl_push_idx),
        .pop      (fl_pop),
        .head_idx (alloc_preg),
        .empty    (fl_empty)
    );

    phys_reg_file u_phys_reg_file (
        .clk          (clk),
        .rst          (rst),
        .alloc_fire   (alloc_fire),
        .alloc_preg   (alloc_preg),
        .alloc_rob_id (alloc_rob_id),
        .cdb_valid    (cdb_valid),
        .cdb_preg     (cdb_preg),
        .cdb_value    (cdb_value),
        .reg_value    (reg_value),
        .reg_busy     (reg_busy),
        .reg_rob_id   (reg_rob_id)
    );

    prf_read_port u_rd_dispatch (
        .rs1        (dispatch_rs1),
        .rs2        (dispatch_rs2),
        .cdb_valid  (cdb_valid),
        .cdb_preg   (cdb_preg),
        .cdb_value  (cdb_value),
        .reg_value  (reg_value),
        .reg_busy   (reg_busy),
        .reg_rob_id (reg_rob_id),
        .rs1_value  (dispatch_rs1_value),
        .rs1_busy   (dispatch_rs1_busy),
        .rs1_rob_id (dispatch_rs1_rob_id),
        .rs2_value  (dispatch_rs2_value),
        .rs2_busy   (dispatch_rs2_busy),
        .rs2_rob_id (dispatch_rs2_rob_id)
    );

    prf_read_port u_rd_alu (
        .rs1        (alu_rs1),
        .rs2        (alu_rs2),
        .cdb_valid  (cdb_valid),
        .cdb_preg   (cdb_preg),
        .cdb_value  (cdb_value),
        .reg_value  (reg_value),
        .reg_busy   (reg_busy),
        .reg_rob_id (reg_rob_id),
        .rs1_value  (alu_rs1_value),
        .rs1_busy   (alu_rs1_busy),
        .rs1_rob_id (alu_rs1_rob_id),
        .rs2_value  (alu_rs2_value),
        .rs2_busy   (alu_rs2_busy),
        .rs2_rob_id (alu_rs2_rob_id)
    );

    prf_read_port u_rd_mul (
        .rs1        (mul_rs1),
        .rs2        (mul_rs2),
        .cdb_valid  (cdb_valid),
        .cdb_preg   (cdb_preg),
        .cdb_value  (cdb_value),
        .reg_value  (reg_value),
        .reg_busy   (reg_busy),
        .reg_rob_id (reg_rob_id),
        .rs1_value  (mul_rs1_value),
        .rs1_busy   (mul_rs1_busy),
        .rs1_rob_id (mul_rs1_rob_id),
        .rs2_value  (mul_rs2_value),
        .rs2_busy   (mul_rs2_busy),
        .rs2_rob_id (mul_rs2_rob_id)
    );

endmodule

//--- verif/prf_checker.sv
//==========================================================================
// Concurrent assertions on the register file top-level ports, bound to prf_top
//==========================================================================

module prf_checker (
    input logic               clk,
    input logic               rst,
    input logic               alloc_ready,
    input prf_pkg::preg_idx_t alloc_preg,
    input prf_pkg::preg_idx_t dispatch_rs1,
    input prf_pkg::preg_idx_t dispatch_rs2,
    input prf_pkg::preg_idx_t alu_rs1,
    input prf_pkg::preg_idx_t alu_rs2,
    input prf_pkg::preg_idx_t mul_rs1,
    input prf_pkg::preg_idx_t mul_rs2,
    input logic               dispatch_rs1_busy,
    input logic               dispatch_rs2_busy,
    input logic               alu_rs1_busy,
    input logic               alu_rs2_busy,
    input logic               mul_rs1_busy,
    input logic               mul_rs2_busy
);

    // Some operand reads x0 and reports it busy
    logic zero_busy;

    assign zero_busy = ((dispatch_rs1 == '0) && dispatch_rs1_busy)
                    || ((dispatch_rs2 == '0) && dispatch_rs2_busy)
                    || ((alu_rs1 == '0) && alu_rs1_busy)
                    || ((alu_rs2 == '0) && alu_rs2_busy)
                    || ((mul_rs1 == '0) && mul_rs1_busy)
                    || ((mul_rs2 == '0) && mul_rs2_busy);

    // Controller sits in INIT right after reset
    a_ready_low_after_rst: assert property (@(posedge clk) rst |=> !alloc_ready)
        else $error("alloc_ready high in the cycle after reset");

    // x0 must never be handed out
    a_no_zero_alloc: assert property (@(posedge clk) disable iff (rst)
        alloc_ready |-> (alloc_preg != '0))
        else $error("alloc_preg is 0 while alloc_ready is high");

    a_zero_not_busy: assert property (@(posedge clk) disable iff (rst) !zero_busy)
        else $error("read of index 0 reported busy");

endmodule

bind prf_top prf_checker u_prf_checker (.*);

//--- verif/prf_tb.sv
//==========================================================================
// Testbench: random alloc, commit and CDB traffic against a reference model
//==========================================================================

`include "prf_params.svh"

module prf_tb;

    localparam int NUM_RD        = 6;
    localparam int READY_TIMEOUT = 200;

    logic               clk;
    logic               rst;
    logic               alloc_valid;
    prf_pkg::rob_id_t   alloc_rob_id;
    logic               alloc_ready;
    prf_pkg::preg_idx_t alloc_preg;
    logic               commit_valid;
    prf_pkg::preg_idx_t commit_preg;
    logic               cdb_valid [`CDB_PORTS];
    prf_pkg::preg_idx_t cdb_preg [`CDB_PORTS];
    prf_pkg::word_t     cdb_value [`CDB_PORTS];

    // Operands in order dispatch rs1, rs2, alu rs1, rs2, mul rs1, rs2
    prf_pkg::preg_idx_t rd_idx [NUM_RD];
    prf_pkg::word_t     rd_value [NUM_RD];
    logic               rd_busy [NUM_RD];
    prf_pkg::rob_id_t   rd_rob_id [NUM_RD];

    // Reference model of storage and free list
    prf_pkg::word_t     m_value [`PRF_ENTRIES];
    logic               m_busy [`PRF_ENTRIES];
    prf_pkg::rob_id_t   m_rob_id [`PRF_ENTRIES];
    prf_pkg::preg_idx_t m_free [$];
    // Allocated indices that may still be committed
    prf_pkg::preg_idx_t m_in_use [$];
    prf_pkg::preg_idx_t last_alloc;

    int  err_idx;
    int  err_word;
    int  err_rob;
    int  err_bit;
    int  err_other;
    int  ignored_allocs;
    int  seed_val;
    bit  ready_ok;

    prf_top u_prf_top (
        .clk                 (clk),
        .rst                 (rst),
        .alloc_valid         (alloc_valid),
        .alloc_rob_id        (alloc_rob_id),
        .alloc_ready         (alloc_ready),
        .alloc_preg          (alloc_preg),
        .commit_valid        (commit_valid),
        .commit_preg         (commit_preg),
        .cdb_valid           (cdb_valid),
        .cdb_preg            (cdb_preg),
        .cdb_value           (cdb_value),
        .dispatch_rs1        (rd_idx[0]),
        .dispatch_rs2        (rd_idx[1]),
        .dispatch_rs1_value  (rd_value[0]),
        .dispatch_rs1_busy   (rd_busy[0]),
        .dispatch_rs1_rob_id (rd_rob_id[0]),
        .dispatch_rs2_value  (rd_value[1]),
        .dispatch_rs2_busy   (rd_busy[1]),
        .dispatch_rs2_rob_id (rd_rob_id[1]),
        .alu_rs1             (rd_idx[2]),
        .alu_rs2             (rd_idx[3]),
        .alu_rs1_value       (rd_value[2]),
        .alu_rs1_busy        (rd_busy[2]),
        .alu_rs1_rob_id      (rd_rob_id[2]),
        .alu_rs2_value       (rd_value[3]),
        .alu_rs2_busy        (rd_busy[3]),
        .alu_rs2_rob_id      (rd_rob_id[3]),
        .mul_rs1             (rd_idx[4]),
        .mul_rs2             (rd_idx[5]),
        .mul_rs1_value       (rd_value[4]),
        .mul_rs1_busy        (rd_busy[4]),
        .mul_rs1_rob_id      (rd_rob_id[4]),
        .mul_rs2_value       (rd_value[5]),
        .mul_rs2_busy        (rd_busy[5]),
        .mul_rs2_rob_id      (rd_rob_id[5])
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_idx(input string what, input prf_pkg::preg_idx_t got,
                             input prf_pkg::preg_idx_t exp);
        if (got !== exp) begin
            err_idx++;
            $display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input string what, input prf_pkg::word_t got,
                              input prf_pkg::word_t exp);
        if (got !== exp) begin
            err_word++;
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_rob(input string what, input prf_pkg::rob_id_t got,
                             input prf_pkg::rob_id_t exp);
        if (got !== exp) begin
            err_rob++;
            $display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            err_bit++;
            $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Expected read: stored entry, overridden by the lowest matching CDB port
    task automatic check_read(input int k);
        prf_pkg::preg_idx_t idx;
        prf_pkg::word_t     exp_value;
        logic               exp_busy;
        bit                 fwd;
        idx       = rd_idx[k];
        exp_value = m_value[idx];
        exp_busy  = m_busy[idx];
        fwd       = 1'b0;
        for (int p = 0; p < `CDB_PORTS; p++) begin
            if (!fwd && (idx != '0) && cdb_valid[p] && (cdb_preg[p] == idx)) begin
                fwd       = 1'b1;
                exp_value = cdb_value[p];
                exp_busy  = 1'b0;
            end
        end
        check_word($sformatf("operand %0d value of p%0d", k, idx), rd_value[k], exp_value);
        check_bit($sformatf("operand %0d busy of p%0d", k, idx), rd_busy[k], exp_busy);
        check_rob($sformatf("operand %0d tag of p%0d", k, idx), rd_rob_id[k], m_rob_id[idx]);
    endtask

    task automatic drive_random(input int alloc_pct, input int commit_pct);
        int pick;
        alloc_valid  = ($urandom_range(0, 99) < alloc_pct);
        alloc_rob_id = prf_pkg::rob_id_t'($urandom);
        commit_valid = 1'b0;
        if ((m_in_use.size() != 0) && ($urandom_range(0, 99) < commit_pct)) begin
            pick         = $urandom_range(0, m_in_use.size() - 1);
            commit_valid = 1'b1;
            commit_preg  = m_in_use[pick];
            m_in_use.delete(pick);
        end
        for (int p = 0; p < `CDB_PORTS; p++) begin
            cdb_valid[p] = ($urandom_range(0, 1) == 1);
            // Index 0 shows up often so the x0 drop is exercised
            cdb_preg[p]  = ($urandom_range(0, 7) == 0) ? '0 : prf_pkg::preg_idx_t'($urandom);
            cdb_value[p] = $urandom;
            // Two ports never target one index
            for (int q = 0; q < p; q++) begin
                if (cdb_preg[q] == cdb_preg[p]) begin
                    cdb_valid[p] = 1'b0;
                end
            end
        end
        for (int k = 0; k < NUM_RD; k++) begin
            case ($urandom_range(0, 4))
                0:       rd_idx[k] = cdb_preg[k % `CDB_PORTS];
                1:       rd_idx[k] = last_alloc;
                2:       rd_idx[k] = '0;
                default: rd_idx[k] = prf_pkg::preg_idx_t'($urandom);
            endcase
        end
    endtask

    task automatic check_outputs();
        check_bit("alloc_ready", alloc_ready, m_free.size() != 0);
        if (m_free.size() != 0) begin
            check_idx("alloc_preg", alloc_preg, m_free[0]);
        end
        for (int k = 0; k < NUM_RD; k++) begin
            check_read(k);
        end
    endtask

    // State after the coming edge: CDB writes first, allocation wins
    task automatic update_model();
        prf_pkg::preg_idx_t idx;
        for (int p = 0; p < `CDB_PORTS; p++) begin
            if (cdb_valid[p] && (cdb_preg[p] != '0)) begin
                m_value[cdb_preg[p]] = cdb_value[p];
                m_busy[cdb_preg[p]]  = 1'b0;
            end
        end
        if (alloc_valid && (m_free.size() != 0)) begin
            idx           = m_free.pop_front();
            m_busy[idx]   = 1'b1;
            m_rob_id[idx] = alloc_rob_id;
            m_in_use.push_back(idx);
            last_alloc = idx;
        end else if (alloc_valid) begin
            ignored_allocs++;
        end
        if (commit_valid) begin
            m_free.push_back(commit_preg);
        end
    endtask

    task automatic run_phase(input int cycles, input int alloc_pct, input int commit_pct);
        repeat (cycles) begin
            @(negedge clk);
            drive_random(alloc_pct, commit_pct);
            // Let the combinational read paths settle before sampling
            #10;
            check_outputs();
            update_model();
        end
    endtask

    // Ready should rise once indices 1 to 63 are seeded
    task automatic wait_for_ready(output bit ok);
        int cycles;
        cycles = 0;
        ok     = 1'b0;
        while (!ok && (cycles < READY_TIMEOUT)) begin
            @(negedge clk);
            cycles++;
            if (alloc_ready === 1'b1) begin
                ok = 1'b1;
            end
        end
        if (!ok) begin
            err_other++;
            $display("alloc_ready did not rise within %0d cycles after reset", READY_TIMEOUT);
        end else if (cycles != (`PRF_ENTRIES - 1)) begin
            err_other++;
            $display("error at %0t: alloc_ready rose after %0d cycles, expected %0d",
                     $time, cycles, `PRF_ENTRIES - 1);
        end
    endtask

    initial begin
        seed_val     = $urandom(24975);
        rst          = 1'b1;
        alloc_valid  = 1'b0;
        alloc_rob_id = '0;
        commit_valid = 1'b0;
        commit_preg  = '0;
        last_alloc   = '0;
        for (int p = 0; p < `CDB_PORTS; p++) begin
            cdb_valid[p] = 1'b0;
            cdb_preg[p]  = '0;
            cdb_value[p] = '0;
        end
        for (int k = 0; k < NUM_RD; k++) begin
            rd_idx[k] = '0;
        end
        for (int e = 0; e < `PRF_ENTRIES; e++) begin
            m_value[e]  = '0;
            m_busy[e]   = 1'b0;
            m_rob_id[e] = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        wait_for_ready(ready_ok);
        if (ready_ok) begin
            for (int i = 1; i < `PRF_ENTRIES; i++) begin
                m_free.push_back(prf_pkg::preg_idx_t'(i));
            end
            // Heavy allocation drains the list, then commits refill it
            run_phase(600, 70, 20);
            run_phase(600, 40, 50);
            if (ignored_allocs == 0) begin
                err_other++;
                $display("free list never ran empty during the random run");
            end
        end
        $display("error counts: index %0d, data %0d, tag %0d, busy %0d, other %0d",
                 err_idx, err_word, err_rob, err_bit, err_other);
        if ((err_idx + err_word + err_rob + err_bit + err_other) == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
